/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := controlUnitTb
FILELIST := all.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* all.f */
isaPkg.sv
ctrlPkg.sv
controlIf.sv
instrDecoder.sv
sequencer.sv
controlWordRom.sv
controlUnit.sv
controlUnit_props.sv
controlUnitTb.sv

/* controlIf.sv */
`timescale 1ns/100ps

interface controlIf;
	import ctrlPkg::*;

	pcCtrlT  pcCtrl;
	aluCtrlT aluCtrl;
	memCtrlT memCtrl;
	regCtrlT regCtrl;

	modport producer (
		output pcCtrl,
		output aluCtrl,
		output memCtrl,
		output regCtrl
	);

	modport consumer (
		input pcCtrl,
		input aluCtrl,
		input memCtrl,
		input regCtrl
	);

endinterface : controlIf

/* controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
	input  logic              clock,
	input  logic              reset,
	input  logic              overflow,
	input  isaPkg::opcodeT    opcode,
	input  isaPkg::functT     funct,
	output ctrlPkg::pcSrcT    srcPc,
	output logic              pcWri,
	output logic              pcWriCond,
	output logic              epcWrite,
	output logic              ulaSrcA,
	output ctrlPkg::aluSrcBT  ulaSrcB,
	output ctrlPkg::aluOpT    ulaOp,
	output logic              aluOutCtrl,
	output logic              iorD,
	output logic              writeMem,
	output ctrlPkg::memWidthT selMemWrite,
	output logic              storeMem,
	output logic              irEsc,
	output logic              escReg,
	output logic              regDst,
	output ctrlPkg::memToRegT mem2Reg,
	output logic              regALoad,
	output logic              regBLoad,
	output ctrlPkg::stateT    stateOut
);
	import ctrlPkg::*;

	instrClassT instrClass;
	memKindT    memKind;
	rKindT      rKind;
	stateT      state;

	controlIf ctrl ();

	instrDecoder decoder (
		.opcode     (opcode),
		.funct      (funct),
		.instrClass (instrClass),
		.memKind    (memKind),
		.rKind      (rKind)
	);

	sequencer seq (
		.clock      (clock),
		.reset      (reset),
		.overflow   (overflow),
		.instrClass (instrClass),
		.memKind    (memKind),
		.rKind      (rKind),
		.state      (state)
	);

	controlWordRom rom (
		.state (state),
		.ctrl  (ctrl.producer)
	);

	assign stateOut = state;

	assign srcPc = ctrl.pcCtrl.srcPc;
	assign pcWri = ctrl.pcCtrl.pcWri;
	assign pcWriCond = ctrl.pcCtrl.pcWriCond;
	assign epcWrite = ctrl.pcCtrl.epcWrite;

	assign ulaSrcA = ctrl.aluCtrl.ulaSrcA;
	assign ulaSrcB = ctrl.aluCtrl.ulaSrcB;
	assign ulaOp = ctrl.aluCtrl.ulaOp;
	assign aluOutCtrl = ctrl.aluCtrl.aluOutCtrl;

	assign iorD = ctrl.memCtrl.iorD;
	assign writeMem = ctrl.memCtrl.writeMem;
	assign selMemWrite = ctrl.memCtrl.selMemWrite;
	assign storeMem = ctrl.memCtrl.storeMem;
	assign irEsc = ctrl.memCtrl.irEsc;

	assign escReg = ctrl.regCtrl.escReg;
	assign regDst = ctrl.regCtrl.regDst;
	assign mem2Reg = ctrl.regCtrl.mem2Reg;
	assign regALoad = ctrl.regCtrl.regALoad;
	assign regBLoad = ctrl.regCtrl.regBLoad;

endmodule : controlUnit

/* controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb;
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int DirectedTests = 20;
	localparam int RandomTests = 40;
	localparam int TestCount = DirectedTests + RandomTests + 2; // Break and restart
	localparam int CycleLimit = TestCount * 12 + 20;

	typedef struct packed {
		pcCtrlT  pcW;
		aluCtrlT aluW;
		memCtrlT memW;
		regCtrlT regW;
	} ctrlWordT;

	logic      clock;
	logic      reset;
	logic      overflow;
	opcodeT    opcode;
	functT     funct;
	pcSrcT     srcPc;
	logic      pcWri;
	logic      pcWriCond;
	logic      epcWrite;
	logic      ulaSrcA;
	aluSrcBT   ulaSrcB;
	aluOpT     ulaOp;
	logic      aluOutCtrl;
	logic      iorD;
	logic      writeMem;
	memWidthT  selMemWrite;
	logic      storeMem;
	logic      irEsc;
	logic      escReg;
	logic      regDst;
	memToRegT  mem2Reg;
	logic      regALoad;
	logic      regBLoad;
	stateT     stateOut;

	pcCtrlT  pcAct;
	aluCtrlT aluAct;
	memCtrlT memAct;
	regCtrlT regAct;

	string       testName = "reset";
	logic [31:0] rngState = 32'd8;
	int          cycles = 0;

	controlUnit uut (.*);

	assign pcAct = {srcPc, pcWri, pcWriCond, epcWrite};
	assign aluAct = {ulaSrcA, ulaSrcB, ulaOp, aluOutCtrl};
	assign memAct = {iorD, writeMem, selMemWrite, storeMem, irEsc};
	assign regAct = {escReg, regDst, mem2Reg, regALoad, regBLoad};

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState;
	endfunction

	// Next state from the instruction fields
	function automatic stateT nextStateOf(input stateT s, input opcodeT op, input functT fn,
			input logic ovf);
		stateT n;
		n = Fetch;
		case (s)
			Reset: n = Fetch;
			Fetch: n = MemWait;
			MemWait: n = IrLoad;
			IrLoad: n = Decode;
			Decode: begin
				case (op)
					OpLw, OpLbu, OpLhu, OpSw, OpSb, OpSh: n = AddrCalc;
					OpRType: n = RegLoad;
					OpJump: n = JumpOp;
					OpBeq: n = BeqOp;
					OpBne: n = BneOp;
					OpLui: n = LuiOp;
					default: n = Nop;
				endcase
			end
			AddrCalc: begin
				case (op)
					OpLw: n = Lw;
					OpLbu: n = Lbu;
					OpLhu: n = Lhu;
					OpSw: n = Sw;
					OpSb: n = Sb;
					OpSh: n = Sh;
					default: n = Nop;
				endcase
			end
			Lw: n = LwWait;
			LwWait: n = LwWb;
			Lbu: n = LbuMem;
			LbuMem: n = LbuWb;
			Lhu: n = LhuMem;
			LhuMem: n = LhuWb;
			Sb: n = SbMem;
			SbMem: n = SbWrite;
			Sh: n = ShMem;
			ShMem: n = ShWrite;
			RegLoad: begin
				case (fn)
					FnAdd: n = AddOp;
					FnSub: n = SubOp;
					FnAnd: n = AndOp;
					FnXor: n = XorOp;
					FnJr: n = JrOp;
					FnBreak: n = Break;
					default: n = Nop;
				endcase
			end
			AddOp, SubOp: n = ovf ? Overflow : AluWb;
			AndOp, XorOp: n = AluWb;
			Break: n = Break;
			default: n = Fetch;
		endcase
		return n;
	endfunction

	// Control word, one signal at a time
	function automatic ctrlWordT wordOfState(input stateT s);
		ctrlWordT w;
		w = '0;
		w.pcW.pcWri = s inside {Fetch, JumpOp, JrOp, Overflow};
		w.pcW.pcWriCond = s inside {BeqOp, BneOp};
		w.pcW.epcWrite = (s == Overflow);
		case (s)
			JumpOp: w.pcW.srcPc = PcJump;
			BeqOp, BneOp: w.pcW.srcPc = PcAluOut;
			Overflow: w.pcW.srcPc = PcExcept;
			default: w.pcW.srcPc = PcAlu;
		endcase
		if (s == Fetch)
			w.aluW.ulaSrcB = SrcFour;
		case (s)
			Fetch, AddOp: w.aluW.ulaOp = AluAdd;
			SubOp, BeqOp, BneOp: w.aluW.ulaOp = AluSub;
			AndOp: w.aluW.ulaOp = AluAnd;
			XorOp: w.aluW.ulaOp = AluXor;
			default: w.aluW.ulaOp = AluLoad;
		endcase
		w.aluW.aluOutCtrl = s inside {AddOp, SubOp, AndOp, XorOp};
		w.memW.iorD = s inside {Lw, LwWait, LwWb, Lbu, LbuMem, LbuWb, Lhu, LhuMem, LhuWb, Sw};
		w.memW.writeMem = s inside {Sw, SbWrite, ShWrite};
		if (s == SbWrite)
			w.memW.selMemWrite = ByteW;
		else if (s == ShWrite)
			w.memW.selMemWrite = HalfW;
		w.memW.irEsc = (s == IrLoad);
		w.regW.escReg = s inside {LwWb, LbuWb, LhuWb, LuiOp, AluWb};
		w.regW.regDst = (s == AluWb);
		case (s)
			LwWb: w.regW.mem2Reg = FromMem;
			LbuWb: w.regW.mem2Reg = FromByte;
			LhuWb: w.regW.mem2Reg = FromHalf;
			LuiOp: w.regW.mem2Reg = FromLui;
			default: w.regW.mem2Reg = FromAlu;
		endcase
		w.regW.regALoad = (s == RegLoad);
		w.regW.regBLoad = (s == RegLoad);
		return w;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkState(input stateT exp, input stateT act);
		if (act !== exp)
			abortRun($sformatf("Mismatch in %s: state expected %s actual %s",
				testName, exp.name(), act.name()));
	endtask

	task automatic checkPc(input pcCtrlT exp, input pcCtrlT act);
		if (act !== exp)
			abortRun($sformatf("Mismatch in %s: pc control expected %h actual %h",
				testName, exp, act));
	endtask

	task automatic checkAlu(input aluCtrlT exp, input aluCtrlT act);
		if (act !== exp)
			abortRun($sformatf("Mismatch in %s: alu control expected %h actual %h",
				testName, exp, act));
	endtask

	task automatic checkMem(input memCtrlT exp, input memCtrlT act);
		if (act !== exp)
			abortRun($sformatf("Mismatch in %s: mem control expected %h actual %h",
				testName, exp, act));
	endtask

	task automatic checkReg(input regCtrlT exp, input regCtrlT act);
		if (act !== exp)
			abortRun($sformatf("Mismatch in %s: reg control expected %h actual %h",
				testName, exp, act));
	endtask

	// Outputs are settled at the falling edge
	initial begin : compareProc
		stateT    expState;
		ctrlWordT expWord;
		logic     valid;
		valid = 1'b0;
		expState = Reset;
		forever begin
			@(negedge clock);
			if (valid) begin
				expWord = wordOfState(expState);
				checkState(expState, stateOut);
				checkPc(expWord.pcW, pcAct);
				checkAlu(expWord.aluW, aluAct);
				checkMem(expWord.memW, memAct);
				checkReg(expWord.regW, regAct);
			end
			if (reset) begin
				expState = Reset;
				valid = 1'b1;
			end else if (valid)
				expState = nextStateOf(expState, opcode, funct, overflow);
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
			abortRun($sformatf("Timeout: run did not end within %0d cycles", CycleLimit));
	end

	// New fields land while the FSM is in MemWait
	task automatic runInstr(input string name, input opcodeT op, input functT fn,
			input logic ovf);
		do
			@(negedge clock);
		while (stateOut != Fetch);
		@(posedge clock);
		testName = name;
		opcode <= op;
		funct <= fn;
		overflow <= ovf;
	endtask

	initial begin : stimulus
		opcodeT      randOps [13];
		functT       randFns [6];
		logic [31:0] r;
		logic [3:0]  opIdx;
		logic [2:0]  fnIdx;
		randOps = '{OpRType, OpJump, OpBeq, OpBne, OpLui, OpLw, OpLbu, OpLhu,
			OpSw, OpSb, OpSh, 6'h11, 6'h3f}; // Last two are unknown
		randFns = '{FnAdd, FnSub, FnAnd, FnXor, FnJr, 6'h3f};
		reset = 1'b1;
		overflow = 1'b0;
		opcode = OpRType;
		funct = FnAdd;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		runInstr("lw", OpLw, FnAdd, 1'b0);
		runInstr("lbu", OpLbu, FnAdd, 1'b0);
		runInstr("lhu", OpLhu, FnAdd, 1'b0);
		runInstr("sw", OpSw, FnAdd, 1'b0);
		runInstr("sb", OpSb, FnAdd, 1'b0);
		runInstr("sh", OpSh, FnAdd, 1'b0);
		runInstr("add", OpRType, FnAdd, 1'b0);
		runInstr("sub", OpRType, FnSub, 1'b0);
		runInstr("and", OpRType, FnAnd, 1'b0);
		runInstr("xor", OpRType, FnXor, 1'b0);
		runInstr("add overflow", OpRType, FnAdd, 1'b1);
		runInstr("sub overflow", OpRType, FnSub, 1'b1);
		runInstr("and overflow ignored", OpRType, FnAnd, 1'b1);
		runInstr("j", OpJump, FnAdd, 1'b0);
		runInstr("jr", OpRType, FnJr, 1'b0);
		runInstr("beq", OpBeq, FnAdd, 1'b0);
		runInstr("bne", OpBne, FnAdd, 1'b0);
		runInstr("lui", OpLui, FnAdd, 1'b0);
		runInstr("unknown opcode", 6'h3f, FnAdd, 1'b0);
		runInstr("unknown funct", OpRType, 6'h3f, 1'b0);

		for (int i = 0; i < RandomTests; i++) begin
			r = nextRand();
			opIdx = 4'(r[30:16] % 15'd13);
			r = nextRand();
			fnIdx = 3'(r[30:16] % 15'd6);
			runInstr($sformatf("random %0d", i), randOps[opIdx], randFns[fnIdx], r[27]);
		end

		runInstr("break", OpRType, FnBreak, 1'b0);
		do
			@(negedge clock);
		while (stateOut != Break);
		repeat (8) @(negedge clock); // Must stay in Break
		@(posedge clock);
		reset <= 1'b1;
		opcode <= OpLui;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		runInstr("lui after reset", OpLui, FnAdd, 1'b0);
		do
			@(negedge clock);
		while (stateOut != Fetch);
		@(negedge clock);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule : controlUnitTb

/* controlUnit_props.sv */
`timescale 1ns/100ps

module controlUnit_props (
	input logic           clock,
	input logic           reset,
	input logic           writeMem,
	input logic           escReg,
	input logic           epcWrite,
	input ctrlPkg::pcSrcT srcPc,
	input logic           pcWri,
	input logic           pcWriCond,
	input ctrlPkg::stateT stateOut
);
	import ctrlPkg::*;

	memVsRegWrite: assert property (@(posedge clock) disable iff (reset)
		!(writeMem && escReg))
		else $error("writeMem and escReg high in the same cycle");

	epcNeedsExcept: assert property (@(posedge clock) disable iff (reset)
		epcWrite |-> srcPc == PcExcept)
		else $error("epcWrite without PcExcept as PC source");

	pcWriteKinds: assert property (@(posedge clock) disable iff (reset)
		!(pcWri && pcWriCond))
		else $error("pcWri and pcWriCond high in the same cycle");

	decodeLeavesFetch: assert property (@(posedge clock) disable iff (reset)
		stateOut == Decode |=> stateOut != Fetch)
		else $error("Fetch directly after Decode");

endmodule : controlUnit_props

bind controlUnit controlUnit_props props (
	.clock     (clock),
	.reset     (reset),
	.writeMem  (writeMem),
	.escReg    (escReg),
	.epcWrite  (epcWrite),
	.srcPc     (srcPc),
	.pcWri     (pcWri),
	.pcWriCond (pcWriCond),
	.stateOut  (stateOut)
);

/* controlWordRom.sv */
`timescale 1ns/100ps

module controlWordRom (
	input ctrlPkg::stateT state,
	controlIf.producer    ctrl
);
	import ctrlPkg::*;

	pcCtrlT  pcWord;
	aluCtrlT aluWord;
	memCtrlT memWord;
	regCtrlT regWord;

	always_comb begin
		pcWord = '0;
		aluWord = '0;
		memWord = '0;
		regWord = '0;
		case (state)
			Fetch: begin
				pcWord.pcWri = 1'b1; // PC + 4
				aluWord.ulaSrcB = SrcFour;
				aluWord.ulaOp = AluAdd;
			end
			IrLoad: memWord.irEsc = 1'b1;
			Lw, LwWait, Lbu, LbuMem, Lhu, LhuMem: memWord.iorD = 1'b1;
			LwWb: begin
				memWord.iorD = 1'b1;
				regWord.escReg = 1'b1;
				regWord.mem2Reg = FromMem;
			end
			LbuWb: begin
				memWord.iorD = 1'b1;
				regWord.escReg = 1'b1;
				regWord.mem2Reg = FromByte;
			end
			LhuWb: begin
				memWord.iorD = 1'b1;
				regWord.escReg = 1'b1;
				regWord.mem2Reg = FromHalf;
			end
			Sw: begin
				memWord.iorD = 1'b1;
				memWord.writeMem = 1'b1;
				memWord.selMemWrite = WordW;
			end
			SbWrite: begin
				memWord.writeMem = 1'b1;
				memWord.selMemWrite = ByteW; // Byte merged into the read word
			end
			ShWrite: begin
				memWord.writeMem = 1'b1;
				memWord.selMemWrite = HalfW;
			end
			RegLoad: begin
				regWord.regALoad = 1'b1;
				regWord.regBLoad = 1'b1;
			end
			AddOp: begin
				aluWord.ulaOp = AluAdd;
				aluWord.aluOutCtrl = 1'b1;
			end
			SubOp: begin
				aluWord.ulaOp = AluSub;
				aluWord.aluOutCtrl = 1'b1;
			end
			AndOp: begin
				aluWord.ulaOp = AluAnd;
				aluWord.aluOutCtrl = 1'b1;
			end
			XorOp: begin
				aluWord.ulaOp = AluXor;
				aluWord.aluOutCtrl = 1'b1;
			end
			AluWb: begin
				regWord.escReg = 1'b1;
				regWord.regDst = 1'b1; // rd field
				regWord.mem2Reg = FromAlu;
			end
			LuiOp: begin
				regWord.escReg = 1'b1;
				regWord.mem2Reg = FromLui;
			end
			JumpOp: begin
				pcWord.pcWri = 1'b1;
				pcWord.srcPc = PcJump;
			end
			JrOp: begin
				pcWord.pcWri = 1'b1;
				pcWord.srcPc = PcAlu;
			end
			BeqOp, BneOp: begin
				pcWord.pcWriCond = 1'b1; // Datapath qualifies with zero flag
				pcWord.srcPc = PcAluOut;
				aluWord.ulaOp = AluSub;
			end
			Overflow: begin
				pcWord.pcWri = 1'b1;
				pcWord.srcPc = PcExcept;
				pcWord.epcWrite = 1'b1;
			end
			default: ;
		endcase
	end

	assign ctrl.pcCtrl = pcWord;
	assign ctrl.aluCtrl = aluWord;
	assign ctrl.memCtrl = memWord;
	assign ctrl.regCtrl = regWord;

endmodule : controlWordRom

/* ctrlPkg.sv */
package ctrlPkg;

	typedef enum logic [2:0] {
		MemAccess, RType, Jump, Beq, Bne, Lui, Invalid
	} instrClassT;

	typedef enum logic [2:0] {
		LoadWord, LoadByte, LoadHalf, StoreWord, StoreByte, StoreHalf
	} memKindT;

	typedef enum logic [2:0] {
		Add, Sub, And, Xor, Jr, Brk, Bad
	} rKindT;

	typedef enum logic [5:0] {
		Reset, Fetch, MemWait, IrLoad, Decode, AddrCalc,
		Lw, LwWait, LwWb,
		Lbu, LbuMem, LbuWb,
		Lhu, LhuMem, LhuWb,
		Sw,
		Sb, SbMem, SbWrite,
		Sh, ShMem, ShWrite,
		RegLoad, AddOp, SubOp, AndOp, XorOp, AluWb,
		Break, Nop, JumpOp, JrOp, BeqOp, BneOp, LuiOp, Overflow
	} stateT;

	typedef enum logic [1:0] {
		PcAlu      = 2'b00,
		PcAluOut   = 2'b01, // Branch target held in ALUOut
		PcJump     = 2'b10,
		PcExcept   = 2'b11
	} pcSrcT;

	typedef enum logic [1:0] {
		SrcB        = 2'b00,
		SrcFour     = 2'b01,
		SrcImm      = 2'b10,
		SrcImmShift = 2'b11
	} aluSrcBT;

	typedef enum logic [2:0] {
		AluLoad = 3'b000, // Passes source A through
		AluAdd  = 3'b001,
		AluSub  = 3'b010,
		AluAnd  = 3'b011,
		AluXor  = 3'b110
	} aluOpT;

	typedef enum logic [2:0] {
		FromAlu  = 3'b000,
		FromMem  = 3'b001,
		FromLui  = 3'b010,
		FromByte = 3'b011,
		FromHalf = 3'b100
	} memToRegT;

	typedef enum logic [1:0] {
		WordW = 2'b00,
		ByteW = 2'b01,
		HalfW = 2'b10
	} memWidthT;

	typedef struct packed {
		pcSrcT srcPc;
		logic  pcWri;
		logic  pcWriCond;
		logic  epcWrite;
	} pcCtrlT;

	typedef struct packed {
		logic    ulaSrcA;
		aluSrcBT ulaSrcB;
		aluOpT   ulaOp;
		logic    aluOutCtrl;
	} aluCtrlT;

	typedef struct packed {
		logic     iorD;
		logic     writeMem;
		memWidthT selMemWrite;
		logic     storeMem;
		logic     irEsc;
	} memCtrlT;

	typedef struct packed {
		logic     escReg;
		logic     regDst;
		memToRegT mem2Reg;
		logic     regALoad;
		logic     regBLoad;
	} regCtrlT;

endpackage : ctrlPkg

/* instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
	input  isaPkg::opcodeT      opcode,
	input  isaPkg::functT       funct,
	output ctrlPkg::instrClassT instrClass,
	output ctrlPkg::memKindT    memKind,
	output ctrlPkg::rKindT      rKind
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		case (opcode)
			OpRType: instrClass = RType;
			OpJump: instrClass = Jump;
			OpBeq: instrClass = Beq;
			OpBne: instrClass = Bne;
			OpLui: instrClass = Lui;
			OpLw, OpLbu, OpLhu, OpSw, OpSb, OpSh: instrClass = MemAccess;
			default: instrClass = Invalid; // Unknown opcode takes the nop path
		endcase
	end

	always_comb begin
		case (opcode)
			OpLbu: memKind = LoadByte;
			OpLhu: memKind = LoadHalf;
			OpSw: memKind = StoreWord;
			OpSb: memKind = StoreByte;
			OpSh: memKind = StoreHalf;
			default: memKind = LoadWord; // Only read after a memory opcode
		endcase
	end

	always_comb begin
		case (funct)
			FnAdd: rKind = Add;
			FnSub: rKind = Sub;
			FnAnd: rKind = And;
			FnXor: rKind = Xor;
			FnJr: rKind = Jr;
			FnBreak: rKind = Brk;
			default: rKind = Bad;
		endcase
	end

endmodule : instrDecoder

/* isaPkg.sv */
package isaPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// Primary opcodes
	localparam opcodeT OpRType = 6'b000000;
	localparam opcodeT OpJump  = 6'b000010;
	localparam opcodeT OpBeq   = 6'b000100;
	localparam opcodeT OpBne   = 6'b000101;
	localparam opcodeT OpLui   = 6'b001111;
	localparam opcodeT OpLw    = 6'b100011;
	localparam opcodeT OpLbu   = 6'b100100;
	localparam opcodeT OpLhu   = 6'b100101;
	localparam opcodeT OpSw    = 6'b101011;
	localparam opcodeT OpSb    = 6'b101000;
	localparam opcodeT OpSh    = 6'b101001;

	// R-type function field
	localparam functT FnAdd   = 6'b100000;
	localparam functT FnSub   = 6'b100010;
	localparam functT FnAnd   = 6'b100100;
	localparam functT FnXor   = 6'b100110;
	localparam functT FnJr    = 6'b001000;
	localparam functT FnBreak = 6'b001101;

endpackage : isaPkg

/* sequencer.sv */
`timescale 1ns/100ps

module sequencer (
	input  logic                clock,
	input  logic                reset,
	input  logic                overflow,
	input  ctrlPkg::instrClassT instrClass,
	input  ctrlPkg::memKindT    memKind,
	input  ctrlPkg::rKindT      rKind,
	output ctrlPkg::stateT      state
);
	import ctrlPkg::*;

	stateT nextState;

	always_ff @(posedge clock) begin
		if (reset)
			state <= Reset;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = Fetch; // Single execute states fall back to fetch
		case (state)
			Reset: nextState = Fetch;
			Fetch: nextState = MemWait;
			MemWait: nextState = IrLoad;
			IrLoad: nextState = Decode;
			Decode: begin
				case (instrClass)
					MemAccess: nextState = AddrCalc;
					RType: nextState = RegLoad;
					Jump: nextState = JumpOp;
					Beq: nextState = BeqOp;
					Bne: nextState = BneOp;
					Lui: nextState = LuiOp;
					default: nextState = Nop;
				endcase
			end
			AddrCalc: begin
				case (memKind)
					LoadWord: nextState = Lw;
					LoadByte: nextState = Lbu;
					LoadHalf: nextState = Lhu;
					StoreWord: nextState = Sw;
					StoreByte: nextState = Sb;
					StoreHalf: nextState = Sh;
					default: nextState = Nop;
				endcase
			end
			Lw: nextState = LwWait;
			LwWait: nextState = LwWb;
			Lbu: nextState = LbuMem;
			LbuMem: nextState = LbuWb;
			Lhu: nextState = LhuMem;
			LhuMem: nextState = LhuWb;
			Sb: nextState = SbMem;
			SbMem: nextState = SbWrite;
			Sh: nextState = ShMem;
			ShMem: nextState = ShWrite;
			RegLoad: begin
				case (rKind)
					Add: nextState = AddOp;
					Sub: nextState = SubOp;
					And: nextState = AndOp;
					Xor: nextState = XorOp;
					Jr: nextState = JrOp;
					Brk: nextState = Break;
					default: nextState = Nop;
				endcase
			end
			AddOp, SubOp: nextState = overflow ? Overflow : AluWb;
			AndOp, XorOp: nextState = AluWb;
			Break: nextState = Break; // Held until reset
			default: nextState = Fetch;
		endcase
	end

endmodule : sequencer
